/* soc_periph_top.f */
soc_periph_pkg.sv
apb_if.sv
clk_rst_gen.sv
apb_demux.sv
gpio_apb.sv
uart_tx_apb.sv
soc_periph_top.sv
tb_soc_periph_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_soc_periph_top \
  -f soc_periph_top.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1

/* tb_soc_periph_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_soc_periph_top;

  localparam int BIT_CYC = 16;
  localparam int EDGE_LAT = 3;
  localparam int MON_HALF = 4;
  localparam int TIMEOUT_CYCLES = 4 * 10 * BIT_CYC + 2000;
  localparam logic [31:0] SEED = 32'ha77f_283b;

  logic                       dev_clk;
  logic                       reset_n;
  soc_periph_pkg::addr_t      paddr;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  soc_periph_pkg::data_t      pwdata;
  soc_periph_pkg::strb_t      pstrb;
  soc_periph_pkg::data_t      prdata_o;
  logic                       pready_o;
  logic                       pslverr_o;
  soc_periph_pkg::gpio_pins_t gpio_in;
  soc_periph_pkg::gpio_pins_t gpio_out_o;
  soc_periph_pkg::gpio_pins_t gpio_oe_o;
  logic                       irq_o;
  logic                       uart_tx_o;
  logic                       mon_clk_o;
  int                         errors;
  int                         checks;
  int                         cycle_cnt;

  soc_periph_top dut_i (
    .dev_clk    (dev_clk),
    .reset_n    (reset_n),
    .paddr_i    (paddr),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .pwdata_i   (pwdata),
    .pstrb_i    (pstrb),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .irq_o      (irq_o),
    .uart_tx_o  (uart_tx_o),
    .mon_clk_o  (mon_clk_o)
  );

  initial begin
    dev_clk = 1'b0;
    forever #5 dev_clk = ~dev_clk;
  end

  always @(posedge dev_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic soc_periph_pkg::addr_t gpio_addr(input soc_periph_pkg::offs_t offs);
    return {soc_periph_pkg::SLOT_GPIO, offs};
  endfunction

  function automatic soc_periph_pkg::addr_t uart_addr(input soc_periph_pkg::offs_t offs);
    return {soc_periph_pkg::SLOT_UART, offs};
  endfunction

  task automatic check_data(input soc_periph_pkg::data_t got, input soc_periph_pkg::data_t exp,
                            input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, msg, got, exp);
    end
  endtask

  task automatic check_pins(input soc_periph_pkg::gpio_pins_t got,
                            input soc_periph_pkg::gpio_pins_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got 0x%02h expected 0x%02h", $time, msg, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
    end
  endtask

  // setup and access cycles with the response sampled mid access cycle
  task automatic apb_transfer(input logic wr, input soc_periph_pkg::addr_t addr,
                              input soc_periph_pkg::data_t wdata, input soc_periph_pkg::strb_t strb,
                              output soc_periph_pkg::data_t rdata, output logic err);
    @(posedge dev_clk);
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= wdata;
    pstrb   <= strb;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge dev_clk);
    penable <= 1'b1;
    @(negedge dev_clk);
    while (pready_o !== 1'b1) @(negedge dev_clk);
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge dev_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input soc_periph_pkg::addr_t addr, input soc_periph_pkg::data_t wdata,
                           output logic err);
    soc_periph_pkg::data_t unused_rd;
    apb_transfer(1'b1, addr, wdata, 4'hF, unused_rd, err);
  endtask

  task automatic apb_read(input soc_periph_pkg::addr_t addr, output soc_periph_pkg::data_t rdata,
                          output logic err);
    apb_transfer(1'b0, addr, '0, '0, rdata, err);
  endtask

  // pads pass two sync flops and status sets one cycle later
  task automatic drive_pads(input soc_periph_pkg::gpio_pins_t v);
    @(posedge dev_clk);
    gpio_in <= v;
    repeat (EDGE_LAT) @(posedge dev_clk);
    @(negedge dev_clk);
  endtask

  task automatic finish_test(input string name, input int start_errs);
    if (errors == start_errs) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d mismatches", name, errors - start_errs);
    end
  endtask

  task automatic test_reset_values();
    int                    start_errs;
    soc_periph_pkg::data_t rd;
    logic                  err;
    start_errs = errors;
    @(negedge dev_clk);
    check_pins(gpio_out_o, '0, "gpio_out after reset");
    check_pins(gpio_oe_o, '0, "gpio_oe after reset");
    check_bit(irq_o, 1'b0, "irq after reset");
    check_bit(uart_tx_o, 1'b1, "uart line after reset");
    check_bit(mon_clk_o, 1'b0, "monitor clock after reset");
    apb_read(uart_addr(soc_periph_pkg::UART_DIV), rd, err);
    check_bit(err, 1'b0, "divisor read error");
    check_data(rd, 32'd16, "divisor after reset");
    finish_test("reset_values", start_errs);
  endtask

  task automatic test_gpio_output();
    int                         start_errs;
    int                         i;
    soc_periph_pkg::gpio_pins_t out_v;
    soc_periph_pkg::gpio_pins_t oe_v;
    soc_periph_pkg::data_t      rd;
    logic                       err;
    start_errs = errors;
    for (i = 0; i < 4; i++) begin
      out_v = soc_periph_pkg::gpio_pins_t'($urandom);
      oe_v  = soc_periph_pkg::gpio_pins_t'($urandom);
      apb_write(gpio_addr(soc_periph_pkg::GPIO_OUT), soc_periph_pkg::data_t'(out_v), err);
      check_bit(err, 1'b0, "out write error");
      apb_write(gpio_addr(soc_periph_pkg::GPIO_OE), soc_periph_pkg::data_t'(oe_v), err);
      check_bit(err, 1'b0, "oe write error");
      @(negedge dev_clk);
      check_pins(gpio_out_o, out_v, "out pins");
      check_pins(gpio_oe_o, oe_v, "oe pins");
      apb_read(gpio_addr(soc_periph_pkg::GPIO_OUT), rd, err);
      check_data(rd, soc_periph_pkg::data_t'(out_v), "out readback");
      apb_read(gpio_addr(soc_periph_pkg::GPIO_OE), rd, err);
      check_data(rd, soc_periph_pkg::data_t'(oe_v), "oe readback");
    end
    // lane 0 off so the register must hold
    apb_transfer(1'b1, gpio_addr(soc_periph_pkg::GPIO_OUT), soc_periph_pkg::data_t'(~out_v),
                 4'b1110, rd, err);
    check_bit(err, 1'b0, "masked write error");
    @(negedge dev_clk);
    check_pins(gpio_out_o, out_v, "masked write ignored");
    finish_test("gpio_output", start_errs);
  endtask

  task automatic test_gpio_input();
    int                         start_errs;
    soc_periph_pkg::gpio_pins_t pads;
    soc_periph_pkg::data_t      rd;
    logic                       err;
    start_errs = errors;
    pads = soc_periph_pkg::gpio_pins_t'($urandom);
    drive_pads(pads);
    apb_read(gpio_addr(soc_periph_pkg::GPIO_IN), rd, err);
    check_data(rd, soc_periph_pkg::data_t'(pads), "input readback");
    drive_pads('0);
    apb_write(gpio_addr(soc_periph_pkg::GPIO_IRQ_STAT), 32'h7F, err);
    apb_read(gpio_addr(soc_periph_pkg::GPIO_IRQ_STAT), rd, err);
    check_data(rd, 32'h0, "status after clear all");
    apb_write(gpio_addr(soc_periph_pkg::GPIO_IRQ_EN), 32'h01, err);
    drive_pads(6'b000001);
    check_bit(irq_o, 1'b1, "irq on enabled edge");
    apb_write(gpio_addr(soc_periph_pkg::GPIO_IRQ_STAT), 32'h01, err);
    @(negedge dev_clk);
    check_bit(irq_o, 1'b0, "irq after status clear");
    drive_pads(6'b000011);
    check_bit(irq_o, 1'b0, "no irq on disabled edge");
    apb_read(gpio_addr(soc_periph_pkg::GPIO_IRQ_STAT), rd, err);
    check_data(rd, 32'h02, "status of disabled edge");
    apb_write(gpio_addr(soc_periph_pkg::GPIO_IRQ_STAT), 32'h02, err);
    apb_write(gpio_addr(soc_periph_pkg::GPIO_IRQ_EN), 32'h0, err);
    drive_pads('0);
    finish_test("gpio_input", start_errs);
  endtask

  // mid-bit samples counted from the first low level after the start edge
  task automatic sample_frame(input logic [7:0] b);
    int i;
    @(negedge dev_clk);
    while (uart_tx_o !== 1'b0) @(negedge dev_clk);
    repeat (BIT_CYC / 2 - 1) @(negedge dev_clk);
    check_bit(uart_tx_o, 1'b0, "start bit");
    for (i = 0; i < 8; i++) begin
      repeat (BIT_CYC) @(negedge dev_clk);
      check_bit(uart_tx_o, b[i], $sformatf("data bit %0d", i));
    end
    repeat (BIT_CYC) @(negedge dev_clk);
    check_bit(uart_tx_o, 1'b1, "stop bit");
  endtask

  task automatic test_uart_frame();
    int                    start_errs;
    logic [7:0]            b;
    soc_periph_pkg::data_t rd;
    logic                  err;
    logic                  busy_err;
    start_errs = errors;
    b = 8'($urandom);
    apb_write(uart_addr(soc_periph_pkg::UART_DIV), BIT_CYC, err);
    check_bit(err, 1'b0, "divisor write error");
    fork
      sample_frame(b);
      begin
        apb_write(uart_addr(soc_periph_pkg::UART_DATA), {24'h0, b}, err);
        check_bit(err, 1'b0, "data write error");
        repeat (3 * BIT_CYC) @(posedge dev_clk);
        apb_write(uart_addr(soc_periph_pkg::UART_DATA), {24'h0, ~b}, busy_err);
        check_bit(busy_err, 1'b1, "write while busy");
      end
    join
    rd = '0;
    while (rd[1] !== 1'b1) apb_read(uart_addr(soc_periph_pkg::UART_STAT), rd, err);
    check_data(rd, 32'h2, "status after frame");
    repeat (EDGE_LAT) @(posedge dev_clk);
    apb_read(gpio_addr(soc_periph_pkg::GPIO_IRQ_STAT), rd, err);
    check_data(rd, 32'h40, "uart irq seen on gpio bit 6");
    apb_write(gpio_addr(soc_periph_pkg::GPIO_IRQ_EN), 32'h40, err);
    @(negedge dev_clk);
    check_bit(irq_o, 1'b1, "irq from uart done");
    apb_write(uart_addr(soc_periph_pkg::UART_STAT), 32'h2, err);
    apb_write(gpio_addr(soc_periph_pkg::GPIO_IRQ_STAT), 32'h40, err);
    apb_write(gpio_addr(soc_periph_pkg::GPIO_IRQ_EN), 32'h0, err);
    @(negedge dev_clk);
    check_bit(irq_o, 1'b0, "irq after cleanup");
    finish_test("uart_frame", start_errs);
  endtask

  task automatic test_bus_errors();
    int                    start_errs;
    soc_periph_pkg::data_t rd;
    logic                  err;
    start_errs = errors;
    apb_read(12'h700, rd, err);
    check_bit(err, 1'b1, "unmapped slot error");
    check_data(rd, 32'h0, "unmapped slot data");
    apb_read(gpio_addr(8'h14), rd, err);
    check_bit(err, 1'b1, "unknown gpio offset error");
    check_data(rd, 32'h0, "unknown gpio offset data");
    finish_test("bus_errors", start_errs);
  endtask

  task automatic test_mon_clock();
    int   start_errs;
    int   k;
    int   n;
    logic lvl;
    start_errs = errors;
    @(negedge dev_clk);
    lvl = mon_clk_o;
    while (mon_clk_o === lvl) @(negedge dev_clk);
    for (k = 0; k < 2; k++) begin
      lvl = mon_clk_o;
      n = 0;
      while (mon_clk_o === lvl) begin
        @(negedge dev_clk);
        n++;
      end
      check_data(soc_periph_pkg::data_t'(n), MON_HALF, "monitor clock half period");
    end
    finish_test("mon_clock", start_errs);
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    cycle_cnt = 0;
    void'($urandom(SEED));
    reset_n   = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    pstrb     = '0;
    gpio_in   = '0;
    repeat (8) @(posedge dev_clk);
    reset_n <= 1'b1;
    // peripheral reset leaves the three-flop synchronizer
    repeat (soc_periph_pkg::RST_SYNC_STAGES + 1) @(posedge dev_clk);
    test_reset_values();
    test_gpio_output();
    test_gpio_input();
    test_uart_frame();
    test_bus_errors();
    test_mon_clock();
    $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* soc_periph_top.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_periph_top (
  input  wire                           dev_clk,
  input  wire                           reset_n,
  input  wire soc_periph_pkg::addr_t    paddr_i,
  input  wire                           psel_i,
  input  wire                           penable_i,
  input  wire                           pwrite_i,
  input  wire soc_periph_pkg::data_t    pwdata_i,
  input  wire soc_periph_pkg::strb_t    pstrb_i,
  output soc_periph_pkg::data_t         prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  input  wire soc_periph_pkg::gpio_pins_t gpio_in_i,
  output soc_periph_pkg::gpio_pins_t    gpio_out_o,
  output soc_periph_pkg::gpio_pins_t    gpio_oe_o,
  output logic                          irq_o,
  output logic                          uart_tx_o,
  output logic                          mon_clk_o
);

  logic                     periph_rst_n;
  logic                     uart_irq;
  soc_periph_pkg::gpio_in_t gpio_in_vec;

  apb_if up_bus ();
  apb_if uart_bus ();
  apb_if gpio_bus ();

  assign up_bus.paddr   = paddr_i;
  assign up_bus.psel    = psel_i;
  assign up_bus.penable = penable_i;
  assign up_bus.pwrite  = pwrite_i;
  assign up_bus.pwdata  = pwdata_i;
  assign up_bus.pstrb   = pstrb_i;
  assign prdata_o       = up_bus.prdata;
  assign pready_o       = up_bus.pready;
  assign pslverr_o      = up_bus.pslverr;

  // uart interrupt reaches the cpu through a gpio input
  assign gpio_in_vec[soc_periph_pkg::GPIO_PINS-1:0]     = gpio_in_i;
  assign gpio_in_vec[soc_periph_pkg::UART_IRQ_BIT]      = uart_irq;

  clk_rst_gen u_clk_rst_gen (
    .dev_clk        (dev_clk),
    .reset_n        (reset_n),
    .periph_rst_n_o (periph_rst_n),
    .mon_clk_o      (mon_clk_o)
  );

  apb_demux u_apb_demux (
    .up     (up_bus.completer),
    .uart_s (uart_bus.requester),
    .gpio_s (gpio_bus.requester)
  );

  uart_tx_apb u_uart_tx_apb (
    .dev_clk   (dev_clk),
    .rst_n_i   (periph_rst_n),
    .bus       (uart_bus.completer),
    .uart_tx_o (uart_tx_o),
    .irq_o     (uart_irq)
  );

  gpio_apb u_gpio_apb (
    .dev_clk    (dev_clk),
    .rst_n_i    (periph_rst_n),
    .bus        (gpio_bus.completer),
    .gpio_in_i  (gpio_in_vec),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .irq_o      (irq_o)
  );

endmodule

`default_nettype wire

/* uart_tx_apb.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_tx_apb (
  input  wire      dev_clk,
  input  wire      rst_n_i,
  apb_if.completer bus,
  output logic     uart_tx_o,
  output logic     irq_o
);

  logic [soc_periph_pkg::UART_DIV_W-1:0]      div_q;
  logic [soc_periph_pkg::UART_DIV_W-1:0]      cyc_cnt_q;
  logic [soc_periph_pkg::UART_FRAME_BITS-1:0] shift_q;
  logic [soc_periph_pkg::UART_BIT_CNT_W-1:0]  bit_cnt_q;
  logic                                       busy_q;
  logic                                       done_q;
  soc_periph_pkg::offs_t                      offs;
  soc_periph_pkg::data_t                      rd_data;
  logic                                       access;
  logic                                       wr_en;
  logic                                       offs_ok;
  logic                                       wr_busy;
  logic                                       start;
  logic                                       bit_end;
  logic                                       frame_end;
  logic                                       done_clr;

  assign offs    = bus.paddr[soc_periph_pkg::OFFS_W-1:0];
  assign access  = bus.psel & bus.penable;
  assign wr_en   = access & bus.pwrite;
  assign wr_busy = wr_en & (offs == soc_periph_pkg::UART_DATA) & busy_q;
  assign start   = wr_en & (offs == soc_periph_pkg::UART_DATA) & ~busy_q;

  // data register is write only and reads back as zero
  always_comb begin
    offs_ok = 1'b1;
    rd_data = '0;
    case (offs)
      soc_periph_pkg::UART_DATA: rd_data = '0;
      soc_periph_pkg::UART_STAT: rd_data[1:0] = {done_q, busy_q};
      soc_periph_pkg::UART_DIV:  rd_data[soc_periph_pkg::UART_DIV_W-1:0] = div_q;
      default:                   offs_ok = 1'b0;
    endcase
  end

  assign bus.pready  = 1'b1;
  assign bus.pslverr = (access & ~offs_ok) | wr_busy;
  assign bus.prdata  = (bus.psel & ~bus.pwrite & offs_ok) ? rd_data : '0;

  assign bit_end   = (cyc_cnt_q == div_q - 1'b1);
  assign frame_end = bit_end & (bit_cnt_q == soc_periph_pkg::UART_LAST_BIT);
  assign done_clr  = wr_en & (offs == soc_periph_pkg::UART_STAT) & bus.pwdata[1];

  // frame is stop, data, start with the start bit at bit 0
  always_ff @(posedge dev_clk) begin
    if (start) begin
      shift_q <= {1'b1, bus.pwdata[soc_periph_pkg::UART_FRAME_BITS-3:0], 1'b0};
    end else if (busy_q && bit_end) begin
      shift_q <= {1'b1, shift_q[soc_periph_pkg::UART_FRAME_BITS-1:1]};
    end
  end

  always_ff @(posedge dev_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_q     <= soc_periph_pkg::UART_DIV_RESET;
      cyc_cnt_q <= '0;
      bit_cnt_q <= '0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      if (wr_en && offs == soc_periph_pkg::UART_DIV) begin
        div_q <= bus.pwdata[soc_periph_pkg::UART_DIV_W-1:0];
      end
      if (start) begin
        busy_q    <= 1'b1;
        cyc_cnt_q <= '0;
        bit_cnt_q <= '0;
      end else if (busy_q) begin
        if (bit_end) begin
          cyc_cnt_q <= '0;
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (frame_end) begin
            busy_q <= 1'b0;
          end
        end else begin
          cyc_cnt_q <= cyc_cnt_q + 1'b1;
        end
      end
      // end of stop bit beats a clear
      if (busy_q && frame_end) begin
        done_q <= 1'b1;
      end else if (done_clr) begin
        done_q <= 1'b0;
      end
    end
  end

  // line idles high
  assign uart_tx_o = ~busy_q | shift_q[0];
  assign irq_o     = done_q;

endmodule

`default_nettype wire

/* gpio_apb.sv */
`timescale 1ns/10ps
`default_nettype none

module gpio_apb (
  input  wire                        dev_clk,
  input  wire                        rst_n_i,
  apb_if.completer                   bus,
  input  wire soc_periph_pkg::gpio_in_t gpio_in_i,
  output soc_periph_pkg::gpio_pins_t gpio_out_o,
  output soc_periph_pkg::gpio_pins_t gpio_oe_o,
  output logic                       irq_o
);

  soc_periph_pkg::gpio_in_t   sync1_q;
  soc_periph_pkg::gpio_in_t   sync2_q;
  soc_periph_pkg::gpio_in_t   sync_d_q;
  soc_periph_pkg::gpio_in_t   rise;
  soc_periph_pkg::gpio_in_t   stat_clr;
  soc_periph_pkg::gpio_in_t   irq_en_q;
  soc_periph_pkg::gpio_in_t   irq_stat_q;
  soc_periph_pkg::gpio_pins_t out_q;
  soc_periph_pkg::gpio_pins_t oe_q;
  soc_periph_pkg::offs_t      offs;
  soc_periph_pkg::data_t      rd_data;
  logic                       access;
  logic                       wr_en;
  logic                       offs_ok;

  assign offs   = bus.paddr[soc_periph_pkg::OFFS_W-1:0];
  assign access = bus.psel & bus.penable;
  // byte lane 0 carries every register
  assign wr_en  = access & bus.pwrite & bus.pstrb[0];

  always_comb begin
    offs_ok = 1'b1;
    rd_data = '0;
    case (offs)
      soc_periph_pkg::GPIO_OUT:      rd_data[soc_periph_pkg::GPIO_PINS-1:0] = out_q;
      soc_periph_pkg::GPIO_OE:       rd_data[soc_periph_pkg::GPIO_PINS-1:0] = oe_q;
      soc_periph_pkg::GPIO_IN:       rd_data[soc_periph_pkg::GPIO_IN_W-1:0] = sync2_q;
      soc_periph_pkg::GPIO_IRQ_EN:   rd_data[soc_periph_pkg::GPIO_IN_W-1:0] = irq_en_q;
      soc_periph_pkg::GPIO_IRQ_STAT: rd_data[soc_periph_pkg::GPIO_IN_W-1:0] = irq_stat_q;
      default:                       offs_ok = 1'b0;
    endcase
  end

  assign bus.pready  = 1'b1;
  assign bus.pslverr = access & ~offs_ok;
  assign bus.prdata  = (bus.psel & ~bus.pwrite & offs_ok) ? rd_data : '0;

  always_ff @(posedge dev_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q    <= '0;
      oe_q     <= '0;
      irq_en_q <= '0;
    end else if (wr_en) begin
      case (offs)
        soc_periph_pkg::GPIO_OUT:    out_q <= bus.pwdata[soc_periph_pkg::GPIO_PINS-1:0];
        soc_periph_pkg::GPIO_OE:     oe_q <= bus.pwdata[soc_periph_pkg::GPIO_PINS-1:0];
        soc_periph_pkg::GPIO_IRQ_EN: irq_en_q <= bus.pwdata[soc_periph_pkg::GPIO_IN_W-1:0];
        default: ;
      endcase
    end
  end

  // two-flop sync, third flop for edge detect
  always_ff @(posedge dev_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q  <= '0;
      sync2_q  <= '0;
      sync_d_q <= '0;
    end else begin
      sync1_q  <= gpio_in_i;
      sync2_q  <= sync1_q;
      sync_d_q <= sync2_q;
    end
  end

  assign rise     = sync2_q & ~sync_d_q;
  assign stat_clr = (wr_en && offs == soc_periph_pkg::GPIO_IRQ_STAT) ?
                    bus.pwdata[soc_periph_pkg::GPIO_IN_W-1:0] : '0;

  // new edge wins over a clear in the same cycle
  always_ff @(posedge dev_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_stat_q <= '0;
    end else begin
      irq_stat_q <= (irq_stat_q & ~stat_clr) | rise;
    end
  end

  assign irq_o      = |(irq_stat_q & irq_en_q);
  assign gpio_out_o = out_q;
  assign gpio_oe_o  = oe_q;

endmodule

`default_nettype wire

/* apb_demux.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_demux (
  apb_if.completer up,
  apb_if.requester uart_s,
  apb_if.requester gpio_s
);

  soc_periph_pkg::slot_t slot;
  logic                  sel_uart;
  logic                  sel_gpio;

  assign slot     = up.paddr[soc_periph_pkg::SLOT_SEL_MSB:soc_periph_pkg::SLOT_SEL_LSB];
  assign sel_uart = (slot == soc_periph_pkg::SLOT_UART);
  assign sel_gpio = (slot == soc_periph_pkg::SLOT_GPIO);

  // only psel is steered
  assign uart_s.psel    = up.psel & sel_uart;
  assign uart_s.paddr   = up.paddr;
  assign uart_s.penable = up.penable;
  assign uart_s.pwrite  = up.pwrite;
  assign uart_s.pwdata  = up.pwdata;
  assign uart_s.pstrb   = up.pstrb;

  assign gpio_s.psel    = up.psel & sel_gpio;
  assign gpio_s.paddr   = up.paddr;
  assign gpio_s.penable = up.penable;
  assign gpio_s.pwrite  = up.pwrite;
  assign gpio_s.pwdata  = up.pwdata;
  assign gpio_s.pstrb   = up.pstrb;

  // unmapped slots complete at once with an error
  assign up.pready = sel_uart ? uart_s.pready :
                     sel_gpio ? gpio_s.pready : 1'b1;

  assign up.pslverr = sel_uart ? uart_s.pslverr :
                      sel_gpio ? gpio_s.pslverr : 1'b1;

  assign up.prdata = sel_uart ? uart_s.prdata :
                     sel_gpio ? gpio_s.prdata : '0;

endmodule

`default_nettype wire

/* clk_rst_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clk_rst_gen (
  input  wire  dev_clk,
  input  wire  reset_n,
  output logic periph_rst_n_o,
  output logic mon_clk_o
);

  logic [soc_periph_pkg::RST_SYNC_STAGES-1:0] rst_sync_q;
  logic [soc_periph_pkg::MON_CNT_W-1:0]       mon_cnt_q;

  // async assert, release after the last stage fills with ones
  always_ff @(posedge dev_clk or negedge reset_n) begin
    if (!reset_n) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[soc_periph_pkg::RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign periph_rst_n_o = rst_sync_q[soc_periph_pkg::RST_SYNC_STAGES-1];

  // slow clock for watching dev_clk on a pin
  always_ff @(posedge dev_clk or negedge periph_rst_n_o) begin
    if (!periph_rst_n_o) begin
      mon_cnt_q <= '0;
      mon_clk_o <= 1'b0;
    end else if (mon_cnt_q == soc_periph_pkg::MON_CNT_MAX) begin
      mon_cnt_q <= '0;
      mon_clk_o <= ~mon_clk_o;
    end else begin
      mon_cnt_q <= mon_cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* apb_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface apb_if;

  soc_periph_pkg::addr_t paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  soc_periph_pkg::data_t pwdata;
  soc_periph_pkg::strb_t pstrb;
  soc_periph_pkg::data_t prdata;
  logic                  pready;
  logic                  pslverr;

  modport requester (
    output paddr, psel, penable, pwrite, pwdata, pstrb,
    input  prdata, pready, pslverr
  );

  modport completer (
    input  paddr, psel, penable, pwrite, pwdata, pstrb,
    output prdata, pready, pslverr
  );

endinterface

`default_nettype wire

/* soc_periph_pkg.sv */
`default_nettype none

package soc_periph_pkg;

  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // address map, slot in the upper nibble
  localparam int SLOT_SEL_MSB = 11;
  localparam int SLOT_SEL_LSB = 8;
  localparam int SLOT_W = SLOT_SEL_MSB - SLOT_SEL_LSB + 1;
  localparam int OFFS_W = SLOT_SEL_LSB;

  typedef logic [SLOT_W-1:0] slot_t;
  typedef logic [OFFS_W-1:0] offs_t;

  localparam slot_t SLOT_UART = SLOT_W'(0);
  localparam slot_t SLOT_GPIO = SLOT_W'(1);

  localparam int GPIO_PINS = 6;
  localparam int GPIO_IN_W = 7;
  localparam int UART_IRQ_BIT = 6;

  typedef logic [GPIO_PINS-1:0] gpio_pins_t;
  typedef logic [GPIO_IN_W-1:0] gpio_in_t;

  localparam offs_t GPIO_OUT      = 8'h00;
  localparam offs_t GPIO_OE       = 8'h04;
  localparam offs_t GPIO_IN       = 8'h08;
  localparam offs_t GPIO_IRQ_EN   = 8'h0C;
  localparam offs_t GPIO_IRQ_STAT = 8'h10;

  localparam offs_t UART_DATA = 8'h00;
  localparam offs_t UART_STAT = 8'h04;
  localparam offs_t UART_DIV  = 8'h08;

  localparam int UART_DIV_W = 16;
  localparam logic [UART_DIV_W-1:0] UART_DIV_RESET = 16'd16;
  localparam int UART_FRAME_BITS = 10;
  localparam int UART_BIT_CNT_W = $clog2(UART_FRAME_BITS);
  localparam logic [UART_BIT_CNT_W-1:0] UART_LAST_BIT = UART_BIT_CNT_W'(UART_FRAME_BITS - 1);

  localparam int RST_SYNC_STAGES = 3;
  localparam int MON_DIV_HALF = 4;
  localparam int MON_CNT_W = $clog2(MON_DIV_HALF);
  localparam logic [MON_CNT_W-1:0] MON_CNT_MAX = MON_CNT_W'(MON_DIV_HALF - 1);

endpackage

`default_nettype wire
